// ==== vlog.f ====
rtl/rename_pkg.sv
rtl/branch_pkg.sv
rtl/branch_buffer.sv
rtl/rat_table.sv
rtl/ckpt_arbiter.sv
rtl/ckpt_store.sv
rtl/rename_top.sv
testbench/tb_rename.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_rename
RTL_TOP   ?= rename_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_rename.sv ====
`timescale 1ns/1ns

module tb_rename;

    import branch_pkg::*;
    import rename_pkg::*;

    localparam int DEPTH      = 8;
    localparam int RST_CYCLES = 16;
    localparam decode_t    NO_DEC = '{opcode: 7'b0010011, pc: 32'h0};  // ADDI, not a branch
    localparam resolve_t   NO_RES = '0;
    localparam rename_wr_t NO_WR  = '0;

    typedef struct packed {
        decode_t    dec;
        resolve_t   res;
        rename_wr_t wr;
        arch_reg_t  arch;
        phys_reg_t  exp_phys;                   // Lookup after the edge
        logic       exp_full;
        logic       exp_pulse;
        ckpt_tag_t  exp_tag;
        logic       chk_phys;                   // Lookup compared only when set
    } row_t;

    logic       clk;
    logic       rst;
    decode_t    decode;
    resolve_t   resolve;
    rename_wr_t ren_wr;
    arch_reg_t  lookup_arch;
    phys_reg_t  lookup_phys;
    logic       bb_full;
    logic       restore_pulse;
    ckpt_tag_t  restore_tag;

    row_t        rows [$];
    string       names [$];
    int          seed;
    int          cycles;
    int          limit;
    rat_map_t    exp_rat;                       // Model RAT
    rat_map_t    exp_ckpt [DEPTH];              // Model checkpoint slots
    rat_map_t    paste_map;
    int          paste_wait;                    // Rows until the RAT takes paste_map
    logic [31:0] bb_pc [DEPTH];
    logic [DEPTH-1:0] bb_valid;
    logic [DEPTH-1:0] bb_done;
    ckpt_tag_t   bb_head;
    ckpt_tag_t   bb_tail;
    logic [31:0] pc_a;
    logic [31:0] pc_c;
    logic [31:0] pc_d;
    logic [31:0] pcs [9];

    rename_top dut (
        .clk(clk), .rst(rst), .decode(decode), .resolve(resolve), .ren_wr(ren_wr),
        .lookup_arch(lookup_arch), .lookup_phys(lookup_phys), .bb_full(bb_full),
        .restore_pulse(restore_pulse), .restore_tag(restore_tag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    function automatic decode_t decode_of(logic [6:0] op, logic [31:0] pc);
        return '{opcode: op, pc: pc};
    endfunction

    function automatic resolve_t resolution(logic [31:0] pc, logic mis);
        return '{valid: 1'b1, pc: pc, mispredict: mis};
    endfunction

    function automatic rename_wr_t rename_write(arch_reg_t a, phys_reg_t p);
        return '{en: 1'b1, arch: a, phys: p};
    endfunction

    function automatic phys_reg_t rand_phys();
        return phys_reg_t'($random(seed));
    endfunction

    function automatic logic [31:0] rand_pc();
        return $random(seed) & 32'hffff_fffc;   // Word aligned
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_phys(input string name, input phys_reg_t exp, input phys_reg_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s lookup_phys: expected %0d, actual %0d",
                                    name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input ckpt_tag_t exp, input ckpt_tag_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s restore_tag: expected %0d, actual %0d",
                                    name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s %s: expected %b, actual %b",
                                    name, what, exp, act));
        end
    endtask

    // Steps the model one edge and records the row with its expected outputs
    task automatic append_row(input string name, input decode_t d, input resolve_t r,
                              input rename_wr_t w, input arch_reg_t a, input logic chk);
        row_t      row;
        logic      br;
        logic      hit;
        logic      was_full;
        logic      retire;
        ckpt_tag_t h;
        br       = (d.opcode == OP_BRANCH) || (d.opcode == OP_JALR);
        hit      = 1'b0;
        h        = '0;
        was_full = bb_valid[bb_tail];           // Full before this edge
        retire   = bb_valid[bb_head] && bb_done[bb_head];
        for (int i = 0; i < DEPTH; i++) begin
            if (!hit && r.valid && bb_valid[i] && bb_pc[i] == r.pc) begin
                hit = 1'b1;
                h   = ckpt_tag_t'(i);
            end
        end
        if (w.en) begin
            exp_rat[w.arch] = w.phys;
        end
        if (paste_wait > 0) begin
            paste_wait--;
            if (paste_wait == 0) begin
                exp_rat = paste_map;            // Paste beats the rename write
            end
        end
        if (hit && r.mispredict) begin
            paste_map  = exp_ckpt[h];
            paste_wait = 2;                     // RAT restored two edges later
            bb_valid   = '0;
            bb_done    = '0;
            bb_head    = '0;
            bb_tail    = '0;
            if (br) begin
                bb_valid[0] = 1'b1;
                bb_pc[0]    = d.pc;
                exp_ckpt[0] = paste_map;        // Copy waits and sees the pasted map
                bb_tail     = 3'd1;
            end
        end else begin
            if (br && !was_full) begin
                bb_valid[bb_tail] = 1'b1;
                bb_pc[bb_tail]    = d.pc;
                exp_ckpt[bb_tail] = exp_rat;    // Includes this row's rename
                bb_tail++;
            end
            if (hit) begin
                bb_done[h] = 1'b1;
            end
            if (retire) begin
                bb_valid[bb_head] = 1'b0;
                bb_done[bb_head]  = 1'b0;
                bb_head++;
            end
        end
        row = '{dec: d, res: r, wr: w, arch: a, exp_phys: exp_rat[a],
                exp_full: bb_valid[bb_tail], exp_pulse: hit && r.mispredict,
                exp_tag: (hit && r.mispredict) ? h : '0, chk_phys: chk};
        rows.push_back(row);
        names.push_back(name);
    endtask

    // Watchdog, four cycles per row plus reset
    initial begin
        cycles = 0;
        @(posedge clk);
        limit = rows.size() * 4 + RST_CYCLES;
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        stop_on_error($sformatf("Timeout: run passed %0d cycles without finishing", limit));
    end

    initial begin
        rst         = 1'b1;
        decode      = NO_DEC;
        resolve     = NO_RES;
        ren_wr      = NO_WR;
        lookup_arch = '0;
        seed        = 32'h7b09;
        paste_wait  = 0;
        bb_valid    = '0;
        bb_done     = '0;
        bb_head     = '0;
        bb_tail     = '0;
        for (int i = 0; i < 32; i++) begin
            exp_rat[i] = phys_reg_t'(i);        // Identity after reset
        end

        append_row("reset_x0", NO_DEC, NO_RES, NO_WR, 5'd0, 1'b1);
        append_row("reset_x17", NO_DEC, NO_RES, NO_WR, 5'd17, 1'b1);
        append_row("reset_x31", NO_DEC, NO_RES, NO_WR, 5'd31, 1'b1);
        append_row("rename_x3", NO_DEC, NO_RES, rename_write(5'd3, rand_phys()), 5'd3, 1'b1);
        append_row("rename_x4", NO_DEC, NO_RES, rename_write(5'd4, rand_phys()), 5'd4, 1'b1);
        // Branch, younger renames, then paste
        pc_a = rand_pc();
        append_row("branch_a", decode_of(OP_BRANCH, pc_a), NO_RES, NO_WR, 5'd3, 1'b1);
        append_row("after_a_x3", NO_DEC, NO_RES, rename_write(5'd3, rand_phys()), 5'd3, 1'b1);
        append_row("after_a_x4", NO_DEC, NO_RES, rename_write(5'd4, rand_phys()), 5'd4, 1'b1);
        append_row("mispredict_a", NO_DEC, resolution(pc_a, 1'b1), NO_WR, 5'd3, 1'b1);
        append_row("paste_wait_a", NO_DEC, NO_RES, NO_WR, 5'd3, 1'b1);
        append_row("restored_a_x3", NO_DEC, NO_RES, NO_WR, 5'd3, 1'b1);
        append_row("restored_a_x4", NO_DEC, NO_RES, NO_WR, 5'd4, 1'b1);
        // Fill all eight slots, ninth dropped
        for (int i = 0; i < 9; i++) begin
            pcs[i] = rand_pc();
            append_row($sformatf("fill_%0d", i), decode_of(i[0] ? OP_JALR : OP_BRANCH, pcs[i]),
                       NO_RES, rename_write(arch_reg_t'(i + 8), rand_phys()),
                       arch_reg_t'(i + 8), 1'b0);
        end
        append_row("resolve_0", NO_DEC, resolution(pcs[0], 1'b0), NO_WR, 5'd8, 1'b1);
        append_row("resolve_1", NO_DEC, resolution(pcs[1], 1'b0), NO_WR, 5'd9, 1'b1);
        append_row("retire_1", NO_DEC, NO_RES, NO_WR, 5'd10, 1'b1);
        // Paste and new branch in one cycle, copy goes through the pending slot
        pc_c = rand_pc();
        append_row("mispredict_3_branch_c", decode_of(OP_BRANCH, pc_c),
                   resolution(pcs[3], 1'b1), NO_WR, 5'd11, 1'b1);
        append_row("paste_wait_3", NO_DEC, NO_RES, NO_WR, 5'd11, 1'b1);
        append_row("restored_3_x11", NO_DEC, NO_RES, NO_WR, 5'd11, 1'b1);
        append_row("restored_3_x12", NO_DEC, NO_RES, NO_WR, 5'd12, 1'b1);
        append_row("after_c_x11", NO_DEC, NO_RES, rename_write(5'd11, rand_phys()), 5'd11, 1'b1);
        append_row("after_c_x12", NO_DEC, NO_RES, rename_write(5'd12, rand_phys()), 5'd12, 1'b1);
        append_row("mispredict_c", NO_DEC, resolution(pc_c, 1'b1), NO_WR, 5'd11, 1'b1);
        append_row("paste_wait_c", NO_DEC, NO_RES, NO_WR, 5'd11, 1'b1);
        append_row("restored_c_x11", NO_DEC, NO_RES, NO_WR, 5'd11, 1'b1);
        append_row("restored_c_x12", NO_DEC, NO_RES, NO_WR, 5'd12, 1'b1);
        // Nothing should move on these
        pc_d = rand_pc();
        append_row("branch_d", decode_of(OP_JALR, pc_d), NO_RES, NO_WR, 5'd12, 1'b1);
        append_row("non_branch_op", decode_of(7'b0110011, pcs[8]), NO_RES, NO_WR, 5'd4, 1'b1);
        append_row("resolve_no_match", NO_DEC, resolution(pcs[8], 1'b1), NO_WR, 5'd4, 1'b1);
        append_row("idle_x3", NO_DEC, NO_RES, NO_WR, 5'd3, 1'b1);
        append_row("idle_x12", NO_DEC, NO_RES, NO_WR, 5'd12, 1'b1);

        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            decode      = rows[i].dec;          // 2 ns past the edge
            resolve     = rows[i].res;
            ren_wr      = rows[i].wr;
            lookup_arch = rows[i].arch;
            @(posedge clk);
            #1;                                 // Outputs settled after the edge
            if (rows[i].chk_phys) begin
                check_phys(names[i], rows[i].exp_phys, lookup_phys);
            end
            check_flag(names[i], "bb_full", rows[i].exp_full, bb_full);
            check_flag(names[i], "restore_pulse", rows[i].exp_pulse, restore_pulse);
            check_tag(names[i], rows[i].exp_tag, restore_tag);
            #1;
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== rtl/rename_top.sv ====
`timescale 1ns/1ns

module rename_top #(
    parameter int  DEPTH = 8,                           // Branch entries and slots
    parameter type T     = rename_pkg::rat_map_t        // Checkpoint payload
) (
    input  logic                   clk,
    input  logic                   rst,
    input  branch_pkg::decode_t    decode,
    input  branch_pkg::resolve_t   resolve,
    input  rename_pkg::rename_wr_t ren_wr,
    input  rename_pkg::arch_reg_t  lookup_arch,
    output rename_pkg::phys_reg_t  lookup_phys,
    output logic                   bb_full,             // Decoded branches now dropped
    output logic                   restore_pulse,
    output branch_pkg::ckpt_tag_t  restore_tag
);

    import branch_pkg::*;
    import rename_pkg::*;

    ckpt_req_t                copy_req;
    ckpt_req_t                restore_req;
    rat_map_t                 rat_map;                  // Live RAT
    rat_map_t                 load_map;                 // Map being pasted
    logic                     rat_load;
    logic                     store_we;
    logic [$clog2(DEPTH)-1:0] store_addr;
    T                         store_wdata;
    T                         store_rdata;

    assign restore_pulse = restore_req.en;              // Same cycle as the request
    assign restore_tag   = restore_req.tag;

    branch_buffer #(.DEPTH(DEPTH)) u_bb (
        .clk(clk), .rst(rst),
        .decode(decode), .resolve(resolve),
        .copy_req(copy_req), .restore_req(restore_req),
        .full(bb_full)
    );

    rat_table u_rat (
        .clk(clk), .rst(rst),
        .ren_wr(ren_wr),
        .lookup_arch(lookup_arch), .lookup_phys(lookup_phys),
        .map(rat_map),
        .rat_load(rat_load), .load_map(load_map)
    );

    ckpt_arbiter #(.DEPTH(DEPTH)) u_arb (
        .clk(clk), .rst(rst),
        .copy_req(copy_req), .restore_req(restore_req),
        .map(rat_map),
        .store_we(store_we), .store_addr(store_addr),
        .store_wdata(store_wdata), .store_rdata(store_rdata),
        .rat_load(rat_load), .load_map(load_map)
    );

    ckpt_store #(.T(T), .DEPTH(DEPTH)) u_store (
        .clk(clk),
        .we(store_we), .addr(store_addr),
        .wdata(store_wdata), .rdata(store_rdata)
    );

endmodule

// ==== rtl/ckpt_store.sv ====
`timescale 1ns/1ns

module ckpt_store #(
    parameter type T     = rename_pkg::rat_map_t,       // Payload per slot
    parameter int  DEPTH = 8                            // Number of slots
) (
    input  logic                     clk,
    input  logic                     we,                // Write at the edge
    input  logic [$clog2(DEPTH)-1:0] addr,              // Shared read/write address
    input  T                         wdata,
    output T                         rdata              // Combinational read
);

    T mem [DEPTH];                                      // Checkpoint slots

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

// ==== rtl/ckpt_arbiter.sv ====
`timescale 1ns/1ns

module ckpt_arbiter #(
    parameter int DEPTH = 8                             // Checkpoint slots
) (
    input  logic                     clk,
    input  logic                     rst,
    input  branch_pkg::ckpt_req_t    copy_req,          // From branch buffer
    input  branch_pkg::ckpt_req_t    restore_req,       // From branch buffer
    input  rename_pkg::rat_map_t     map,               // Live RAT
    output logic                     store_we,
    output logic [$clog2(DEPTH)-1:0] store_addr,
    output rename_pkg::rat_map_t     store_wdata,
    input  rename_pkg::rat_map_t     store_rdata,       // Combinational read
    output logic                     rat_load,          // Paste strobe to RAT
    output rename_pkg::rat_map_t     load_map
);

    import branch_pkg::*;
    import rename_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic          pend_q;                              // A copy lost arbitration
    ckpt_tag_t     pend_tag_q;
    logic          copy_go;                             // Copy owns the port
    logic [AW-1:0] copy_addr;
    rat_map_t      snap;

    assign copy_go   = !restore_req.en && (pend_q || copy_req.en);  // Restore first
    assign copy_addr = pend_q ? AW'(pend_tag_q) : AW'(copy_req.tag); // Held one is older
    assign load_map  = store_rdata;
    // RAT takes the pasted map at this edge, so that is the state to save
    assign snap      = rat_load ? load_map : map;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_q     <= 1'b0;
            pend_tag_q <= '0;
        end else if (restore_req.en) begin
            if (copy_req.en && !pend_q) begin
                pend_q     <= 1'b1;                     // Park the blocked copy
                pend_tag_q <= copy_req.tag;
            end
        end else if (pend_q) begin
            pend_q <= copy_req.en;                      // Newcomer queues behind
            if (copy_req.en) begin
                pend_tag_q <= copy_req.tag;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            store_we   <= 1'b0;
            store_addr <= '0;
            rat_load   <= 1'b0;
        end else begin
            store_we <= copy_go;
            rat_load <= restore_req.en;                 // Read lands next cycle
            if (restore_req.en) begin
                store_addr <= AW'(restore_req.tag);
            end else if (copy_go) begin
                store_addr <= copy_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (copy_go) begin
            store_wdata <= snap;                        // Snapshot at grant
        end
    end

    // Two restores in a row with branches behind both would drop a copy
    a_pend_free: assert property (@(posedge clk) disable iff (rst)
        restore_req.en && pend_q |-> !copy_req.en);

endmodule

// ==== rtl/rat_table.sv ====
`timescale 1ns/1ns

module rat_table (
    input  logic                   clk,
    input  logic                   rst,
    input  rename_pkg::rename_wr_t ren_wr,          // Rename write from decode
    input  rename_pkg::arch_reg_t  lookup_arch,     // Source operand to translate
    output rename_pkg::phys_reg_t  lookup_phys,     // Its current tag
    output rename_pkg::rat_map_t   map,             // Live map for checkpointing
    input  logic                   rat_load,        // Restore strobe
    input  rename_pkg::rat_map_t   load_map         // Map to restore
);

    import rename_pkg::*;

    rat_map_t map_q;                                // x[i] -> phys tag

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map_q[i] <= phys_reg_t'(i);         // Identity after reset
            end
        end else if (rat_load) begin
            map_q <= load_map;                      // Restore beats rename
        end else if (ren_wr.en) begin
            map_q[ren_wr.arch] <= ren_wr.phys;
        end
    end

    assign lookup_phys = map_q[lookup_arch];        // Combinational lookup
    assign map         = map_q;

endmodule

// ==== rtl/branch_buffer.sv ====
`timescale 1ns/1ns

module branch_buffer #(
    parameter int DEPTH = 8                             // One entry per checkpoint tag
) (
    input  logic                  clk,
    input  logic                  rst,
    input  branch_pkg::decode_t   decode,               // Instr seen by decode
    input  branch_pkg::resolve_t  resolve,              // Outcome from execute
    output branch_pkg::ckpt_req_t copy_req,             // Snapshot RAT into tag
    output branch_pkg::ckpt_req_t restore_req,          // Paste tag back into RAT
    output logic                  full
);

    import branch_pkg::*;

    logic [31:0]      pc_q [DEPTH];                     // PC per entry
    logic [DEPTH-1:0] valid_q;                          // Entry in flight
    logic [DEPTH-1:0] done_q;                           // Resolved as predicted
    ckpt_tag_t        head_q;                           // Oldest entry
    ckpt_tag_t        tail_q;                           // Next slot to fill

    logic             is_br;
    logic             alloc;
    logic             hit;
    ckpt_tag_t        hit_tag;
    logic             flush;
    logic             retire;

    assign is_br  = is_ckpt_op(decode.opcode);
    assign full   = valid_q[tail_q];                    // Tail wrapped onto a live head
    assign alloc  = is_br && !full;                     // Dropped while full
    assign flush  = hit && resolve.mispredict;
    assign retire = valid_q[head_q] && done_q[head_q];  // Head leaves once done

    // Lowest live slot holding the resolve PC wins
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!hit && resolve.valid && valid_q[i] && pc_q[i] == resolve.pc) begin
                hit     = 1'b1;
                hit_tag = ckpt_tag_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            done_q      <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            copy_req    <= '0;
            restore_req <= '0;
        end else if (flush) begin
            valid_q     <= DEPTH'(is_br);               // New branch restarts at slot 0
            done_q      <= '0;
            head_q      <= '0;
            tail_q      <= ckpt_tag_t'(is_br);
            copy_req    <= '{en: is_br, tag: '0};
            restore_req <= '{en: 1'b1, tag: hit_tag};   // Paste the mispredicted slot
        end else begin
            restore_req <= '0;
            copy_req    <= '{en: alloc, tag: tail_q};
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;       // Wraps at DEPTH
            end
            if (hit) begin
                done_q[hit_tag] <= 1'b1;                // Retired from the next edge on
            end
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    // PC storage
    always_ff @(posedge clk) begin
        if (flush && is_br) begin
            pc_q[0] <= decode.pc;
        end else if (alloc) begin
            pc_q[tail_q] <= decode.pc;
        end
    end

    // Pointers wrap by overflow, so the entry count has to fill the tag
    initial begin
        assert (DEPTH == 2 ** $bits(ckpt_tag_t))
            else $error("DEPTH %0d does not fit the checkpoint tag width", DEPTH);
    end

    // Pasted slot lay in the live window from head to tail one cycle earlier
    a_restore_live: assert property (@(posedge clk) disable iff (rst)
        restore_req.en |-> $past(full ||
            ckpt_tag_t'(hit_tag - head_q) < ckpt_tag_t'(tail_q - head_q)));

endmodule

// ==== rtl/branch_pkg.sv ====
package branch_pkg;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // BEQ, BNE, BLT and friends
    localparam logic [6:0] OP_JALR   = 7'b1100111;  // Indirect jump

    localparam int TAG_W = 3;
    typedef logic [TAG_W-1:0] ckpt_tag_t;           // Checkpoint slot index

    typedef struct packed {
        logic [6:0]  opcode;                        // Opcode field of instr
        logic [31:0] pc;                            // PC of that instr
    } decode_t;

    typedef struct packed {
        logic        valid;                         // Branch resolved this cycle
        logic [31:0] pc;                            // PC of the resolved branch
        logic        mispredict;                    // Wrong path was taken
    } resolve_t;

    typedef struct packed {
        logic      en;                              // One-cycle request
        ckpt_tag_t tag;                             // Slot to copy to or paste from
    } ckpt_req_t;

    // Opcodes that need a RAT checkpoint
    function automatic logic is_ckpt_op(logic [6:0] op);
        return (op == OP_BRANCH) || (op == OP_JALR);
    endfunction

endpackage

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    localparam int NUM_ARCH = 32;               // x0..x31 of RV32
    localparam int ARCH_W   = 5;                // Bits to name an arch register
    localparam int PHYS_W   = 6;                // 64 physical registers

    typedef logic [ARCH_W-1:0] arch_reg_t;      // Architectural register number
    typedef logic [PHYS_W-1:0] phys_reg_t;      // Physical register tag

    // Whole alias map, element i is the tag currently holding x[i]
    typedef phys_reg_t [NUM_ARCH-1:0] rat_map_t;

    typedef struct packed {
        logic      en;                          // Write strobe from decode
        arch_reg_t arch;                        // Destination register
        phys_reg_t phys;                        // Freshly allocated tag
    } rename_wr_t;

endpackage
